/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_J,
        IMM_U
    } imm_src_t;

    typedef enum logic [1:0] {
        RES_ALU,
        RES_MEM,
        RES_PC4
    } result_src_t;

    typedef enum logic [1:0] {
        ALU_ADD,   // address and immediate adds
        ALU_SUB,   // branch compare
        ALU_FUNCT  // picked from funct3 and funct7
    } alu_op_t;

    typedef struct packed {
        logic        reg_write;
        imm_src_t    imm_src;
        logic        alu_src;     // 1 takes the immediate as operand b
        logic        mem_write;
        result_src_t result_src;
        logic        branch;
        logic        jal;
        logic        jalr;
        alu_op_t     alu_op;
        logic        halt;        // ebreak
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } fetch_t;

    typedef struct packed {
        logic running;
        logic halted;
    } status_t;

    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_OP     = 7'b0110011;
    localparam logic [6:0] OP_OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

endpackage

`default_nettype wire

/* pipe_reg.sv */
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     flush_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i && !flush_i;  // flush drops the entry being loaded
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            data_o <= data_i;                // holds while nothing valid arrives
        end
    end

endmodule

`default_nettype wire

/* fetch_stage.sv */
`default_nettype none

module fetch_stage #(
    parameter int IMEM_WORDS = 64
) (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          start_i,
    input  logic                          imem_we_i,
    input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr_i,
    input  rv_pkg::word_t                 imem_wdata_i,
    input  logic                          running_i,
    input  logic                          redirect_i,
    input  rv_pkg::word_t                 target_i,
    output rv_pkg::fetch_t                fetch_o,
    output logic                          fetch_valid_o
);
    import rv_pkg::*;

    localparam int AW = $clog2(IMEM_WORDS);

    word_t pc_q;
    word_t pc_next;
    word_t instr_q;
    word_t imem [IMEM_WORDS];

    always_comb begin
        pc_next = pc_q;
        if (start_i) begin
            pc_next = '0;
        end else if (running_i) begin
            pc_next = redirect_i ? target_i : pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_next;
        end
    end

    // the read port is addressed with the next pc, so the word at pc_q is
    // already in instr_q during the cycle it is fetched
    always_ff @(posedge clk_i) begin
        if (imem_we_i) begin
            imem[imem_addr_i] <= imem_wdata_i;  // host load, only while stopped
        end
        if (running_i || start_i) begin
            instr_q <= imem[pc_next[AW+1:2]];
        end
    end

    assign fetch_o.pc    = pc_q;
    assign fetch_o.instr = instr_q;
    assign fetch_valid_o = running_i && !redirect_i;  // wrong-path word

endmodule

`default_nettype wire

/* main_decoder.sv */
`default_nettype none

module main_decoder (
    input  logic [6:0]    op_i,
    input  logic [2:0]    funct3_i,
    input  logic          eq_i,           // operands equal
    output rv_pkg::ctrl_t ctrl_o,
    output logic          pc_src_o,       // jal or taken branch
    output logic          jalr_pc_src_o   // target comes from the ALU
);
    import rv_pkg::*;

    logic taken;

    always_comb begin
        ctrl_o = '0;                      // unknown opcodes act as nop
        case (op_i)
            OP_LOAD: begin
                ctrl_o.reg_write  = 1'b1;
                ctrl_o.imm_src    = IMM_I;
                ctrl_o.alu_src    = 1'b1;
                ctrl_o.result_src = RES_MEM;
                ctrl_o.alu_op     = ALU_ADD;
            end
            OP_STORE: begin
                ctrl_o.imm_src    = IMM_S;
                ctrl_o.alu_src    = 1'b1;
                ctrl_o.mem_write  = 1'b1;
                ctrl_o.alu_op     = ALU_ADD;
            end
            OP_OP: begin
                ctrl_o.reg_write  = 1'b1;
                ctrl_o.alu_op     = ALU_FUNCT;
            end
            OP_OP_IMM: begin
                ctrl_o.reg_write  = 1'b1;
                ctrl_o.imm_src    = IMM_I;
                ctrl_o.alu_src    = 1'b1;
                ctrl_o.alu_op     = ALU_FUNCT;
            end
            OP_BRANCH: begin
                ctrl_o.imm_src    = IMM_B;
                ctrl_o.branch     = 1'b1;
                ctrl_o.alu_op     = ALU_SUB;
            end
            OP_JAL: begin
                ctrl_o.reg_write  = 1'b1;
                ctrl_o.imm_src    = IMM_J;
                ctrl_o.result_src = RES_PC4;   // link
                ctrl_o.jal        = 1'b1;
            end
            OP_JALR: begin
                ctrl_o.reg_write  = 1'b1;
                ctrl_o.imm_src    = IMM_I;
                ctrl_o.alu_src    = 1'b1;
                ctrl_o.result_src = RES_PC4;
                ctrl_o.jalr       = 1'b1;
                ctrl_o.alu_op     = ALU_ADD;   // rs1 + imm
            end
            OP_AUIPC, OP_LUI: begin
                ctrl_o.reg_write  = 1'b1;
                ctrl_o.imm_src    = IMM_U;
                ctrl_o.alu_src    = 1'b1;      // operand a picked in execute
                ctrl_o.alu_op     = ALU_ADD;
            end
            OP_SYSTEM: begin
                ctrl_o.halt       = (funct3_i == 3'b000);  // ebreak
            end
            default: begin
                ctrl_o.halt       = 1'b0;
            end
        endcase
    end

    // beq on equal, bne on not equal, nothing else
    always_comb begin
        case (funct3_i)
            3'b000:  taken = eq_i;
            3'b001:  taken = !eq_i;
            default: taken = 1'b0;
        endcase
    end

    assign pc_src_o      = ctrl_o.jal || (ctrl_o.branch && taken);
    assign jalr_pc_src_o = ctrl_o.jalr;

endmodule

`default_nettype wire

/* alu.sv */
`default_nettype none

module alu (
    input  rv_pkg::alu_op_t alu_op_i,
    input  logic [2:0]      funct3_i,
    input  logic            funct7b5_i,
    input  logic            is_rtype_i,
    input  rv_pkg::word_t   a_i,
    input  rv_pkg::word_t   b_i,
    output rv_pkg::word_t   result_o,
    output logic            eq_o
);
    import rv_pkg::*;

    typedef enum logic [3:0] {
        A_ADD, A_SUB, A_SLL, A_SLT, A_SLTU,
        A_XOR, A_SRL, A_SRA, A_OR,  A_AND
    } op_t;

    op_t op;

    always_comb begin
        case (alu_op_i)
            ALU_ADD: op = A_ADD;
            ALU_SUB: op = A_SUB;
            default: begin
                case (funct3_i)
                    3'b000:  op = (is_rtype_i && funct7b5_i) ? A_SUB : A_ADD;
                    3'b001:  op = A_SLL;
                    3'b010:  op = A_SLT;
                    3'b011:  op = A_SLTU;
                    3'b100:  op = A_XOR;
                    3'b101:  op = funct7b5_i ? A_SRA : A_SRL;  // srai too
                    3'b110:  op = A_OR;
                    default: op = A_AND;
                endcase
            end
        endcase
    end

    always_comb begin
        case (op)
            A_SUB:   result_o = a_i - b_i;
            A_SLL:   result_o = a_i << b_i[4:0];
            A_SLT:   result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            A_SLTU:  result_o = {31'b0, a_i < b_i};
            A_XOR:   result_o = a_i ^ b_i;
            A_SRL:   result_o = a_i >> b_i[4:0];
            A_SRA:   result_o = $signed(a_i) >>> b_i[4:0];
            A_OR:    result_o = a_i | b_i;
            A_AND:   result_o = a_i & b_i;
            default: result_o = a_i + b_i;
        endcase
    end

    assign eq_o = (a_i == b_i);  // feeds beq/bne

endmodule

`default_nettype wire

/* reg_file.sv */
`default_nettype none

module reg_file (
    input  logic          clk_i,
    input  logic [4:0]    rs1_i,
    input  logic [4:0]    rs2_i,
    input  logic [4:0]    rd_i,
    input  logic [4:0]    host_raddr_i,
    input  logic          we_i,
    input  rv_pkg::word_t wdata_i,
    output rv_pkg::word_t rdata1_o,
    output rv_pkg::word_t rdata2_o,
    output rv_pkg::word_t host_rdata_o
);
    import rv_pkg::*;

    word_t regs [1:31];  // x0 has no storage

    always_ff @(posedge clk_i) begin
        if (we_i && rd_i != 5'd0) begin
            regs[rd_i] <= wdata_i;
        end
    end

    assign rdata1_o     = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
    assign rdata2_o     = (rs2_i == 5'd0) ? '0 : regs[rs2_i];
    assign host_rdata_o = (host_raddr_i == 5'd0) ? '0 : regs[host_raddr_i];

endmodule

`default_nettype wire

/* execute_stage.sv */
`default_nettype none

module execute_stage #(
    parameter int DMEM_WORDS = 32
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            start_i,
    input  logic            valid_i,
    input  rv_pkg::fetch_t  fetch_i,
    input  logic [4:0]      host_raddr_i,
    output rv_pkg::word_t   host_rdata_o,
    output logic            redirect_o,
    output rv_pkg::word_t   target_o,
    output logic            flush_o,
    output rv_pkg::status_t status_o,
    output rv_pkg::word_t   retired_o
);
    import rv_pkg::*;

    localparam int DW = $clog2(DMEM_WORDS);

    word_t instr;
    ctrl_t ctrl;
    logic  pc_src;
    logic  jalr_pc_src;
    logic  eq;
    logic  halt;
    word_t imm;
    word_t rs1_data;
    word_t rs2_data;
    word_t src_a;
    word_t src_b;
    word_t alu_result;
    word_t mem_rdata;
    word_t wb_data;
    word_t dmem [DMEM_WORDS];

    assign instr = fetch_i.instr;

    main_decoder u_dec (
        .op_i          (instr[6:0]),
        .funct3_i      (instr[14:12]),
        .eq_i          (eq),
        .ctrl_o        (ctrl),
        .pc_src_o      (pc_src),
        .jalr_pc_src_o (jalr_pc_src)
    );

    reg_file u_rf (
        .clk_i        (clk_i),
        .rs1_i        (instr[19:15]),
        .rs2_i        (instr[24:20]),
        .rd_i         (instr[11:7]),
        .host_raddr_i (host_raddr_i),
        .we_i         (valid_i && ctrl.reg_write),
        .wdata_i      (wb_data),
        .rdata1_o     (rs1_data),
        .rdata2_o     (rs2_data),
        .host_rdata_o (host_rdata_o)
    );

    always_comb begin
        case (ctrl.imm_src)
            IMM_S:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B:   imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            IMM_J:   imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            IMM_U:   imm = {instr[31:12], 12'b0};
            default: imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    // opcode bit 5 tells lui (zero base) from auipc (pc base)
    always_comb begin
        if (ctrl.imm_src == IMM_U) begin
            src_a = instr[5] ? '0 : fetch_i.pc;
        end else begin
            src_a = rs1_data;
        end
    end

    assign src_b = ctrl.alu_src ? imm : rs2_data;

    alu u_alu (
        .alu_op_i   (ctrl.alu_op),
        .funct3_i   (instr[14:12]),
        .funct7b5_i (instr[30]),
        .is_rtype_i (instr[5]),
        .a_i        (src_a),
        .b_i        (src_b),
        .result_o   (alu_result),
        .eq_o       (eq)
    );

    assign mem_rdata = dmem[alu_result[DW+1:2]];  // word access only

    always_ff @(posedge clk_i) begin
        if (valid_i && ctrl.mem_write) begin
            dmem[alu_result[DW+1:2]] <= rs2_data;
        end
    end

    always_comb begin
        case (ctrl.result_src)
            RES_MEM: wb_data = mem_rdata;
            RES_PC4: wb_data = fetch_i.pc + 32'd4;
            default: wb_data = alu_result;
        endcase
    end

    assign redirect_o = valid_i && (pc_src || jalr_pc_src);
    assign target_o   = jalr_pc_src ? {alu_result[31:1], 1'b0} : fetch_i.pc + imm;
    assign halt       = valid_i && ctrl.halt;
    assign flush_o    = redirect_o || halt;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            status_o  <= '0;
            retired_o <= '0;
        end else if (start_i) begin
            status_o.running <= 1'b1;
            status_o.halted  <= 1'b0;
            retired_o        <= '0;
        end else begin
            if (valid_i) begin
                retired_o <= retired_o + 32'd1;  // ebreak counts as well
            end
            if (halt) begin
                status_o.running <= 1'b0;
                status_o.halted  <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* apb_host_port.sv */
`default_nettype none

module apb_host_port #(
    parameter int IMEM_WORDS = 64
) (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  rv_pkg::word_t                 paddr_i,
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  rv_pkg::word_t                 pwdata_i,
    output rv_pkg::word_t                 prdata_o,
    output logic                          pready_o,
    output logic                          pslverr_o,
    input  rv_pkg::status_t               status_i,
    input  rv_pkg::word_t                 retired_i,
    input  rv_pkg::word_t                 host_rdata_i,
    output logic [4:0]                    host_raddr_o,
    output logic                          imem_we_o,
    output logic [$clog2(IMEM_WORDS)-1:0] imem_addr_o,
    output rv_pkg::word_t                 imem_wdata_o,
    output logic                          start_o
);
    import rv_pkg::*;

    localparam int    AW         = $clog2(IMEM_WORDS);
    localparam word_t IMEM_BYTES = word_t'(IMEM_WORDS * 4);

    typedef enum logic [2:0] {
        RG_NONE,
        RG_IMEM,
        RG_REGS,
        RG_CTRL,
        RG_STAT,
        RG_RET
    } region_t;

    region_t region_d;
    region_t region_q;
    logic    access;
    logic    err;

    assign access = psel_i && penable_i;

    always_comb begin
        region_d = RG_NONE;
        if (paddr_i[1:0] != 2'b00) begin
            region_d = RG_NONE;                 // unaligned
        end else if (paddr_i < IMEM_BYTES) begin
            region_d = RG_IMEM;
        end else if (paddr_i[31:7] == 25'h2) begin
            region_d = RG_REGS;                 // 0x100 to 0x17c
        end else if (paddr_i == 32'h180) begin
            region_d = RG_CTRL;
        end else if (paddr_i == 32'h184) begin
            region_d = RG_STAT;
        end else if (paddr_i == 32'h188) begin
            region_d = RG_RET;
        end
    end

    // decode once in the setup cycle, address is stable into access
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            region_q <= RG_NONE;
        end else if (psel_i && !penable_i) begin
            region_q <= region_d;
        end
    end

    always_comb begin
        case (region_q)
            RG_IMEM:                  err = !pwrite_i || status_i.running;
            RG_REGS, RG_STAT, RG_RET: err = pwrite_i;   // read only
            RG_CTRL:                  err = !pwrite_i;  // write only
            default:                  err = 1'b1;
        endcase
    end

    always_comb begin
        prdata_o = '0;
        if (access && !pwrite_i) begin
            case (region_q)
                RG_REGS: prdata_o = host_rdata_i;
                RG_STAT: prdata_o = {30'b0, status_i};
                RG_RET:  prdata_o = retired_i;
                default: prdata_o = '0;
            endcase
        end
    end

    assign pready_o     = access;              // zero wait states
    assign pslverr_o    = access && err;
    assign host_raddr_o = paddr_i[6:2];
    assign imem_we_o    = access && pwrite_i && region_q == RG_IMEM && !err;
    assign imem_addr_o  = paddr_i[AW+1:2];
    assign imem_wdata_o = pwdata_i;
    assign start_o      = access && pwrite_i && region_q == RG_CTRL && pwdata_i[0];

endmodule

`default_nettype wire

/* rv_core_top.sv */
`default_nettype none

module rv_core_top #(
    parameter int IMEM_WORDS = 64,
    parameter int DMEM_WORDS = 32
) (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  rv_pkg::word_t paddr_i,
    input  logic          psel_i,
    input  logic          penable_i,
    input  logic          pwrite_i,
    input  rv_pkg::word_t pwdata_i,
    output rv_pkg::word_t prdata_o,
    output logic          pready_o,
    output logic          pslverr_o
);
    import rv_pkg::*;

    localparam int AW = $clog2(IMEM_WORDS);

    status_t       status;
    word_t         retired;
    word_t         host_rdata;
    logic [4:0]    host_raddr;
    logic          imem_we;
    logic [AW-1:0] imem_addr;
    word_t         imem_wdata;
    logic          start;
    fetch_t        fetch_f;      // fetch side of the pipeline register
    fetch_t        fetch_e;      // execute side
    logic          fetch_valid;
    logic          exec_valid;
    logic          redirect;
    word_t         target;
    logic          flush;

    apb_host_port #(.IMEM_WORDS(IMEM_WORDS)) u_apb (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .paddr_i      (paddr_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .status_i     (status),
        .retired_i    (retired),
        .host_rdata_i (host_rdata),
        .host_raddr_o (host_raddr),
        .imem_we_o    (imem_we),
        .imem_addr_o  (imem_addr),
        .imem_wdata_o (imem_wdata),
        .start_o      (start)
    );

    fetch_stage #(.IMEM_WORDS(IMEM_WORDS)) u_fetch (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .start_i       (start),
        .imem_we_i     (imem_we),
        .imem_addr_i   (imem_addr),
        .imem_wdata_i  (imem_wdata),
        .running_i     (status.running),
        .redirect_i    (redirect),
        .target_i      (target),
        .fetch_o       (fetch_f),
        .fetch_valid_o (fetch_valid)
    );

    pipe_reg #(.payload_t(fetch_t)) u_pipe (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush),
        .valid_i (fetch_valid),
        .data_i  (fetch_f),
        .valid_o (exec_valid),
        .data_o  (fetch_e)
    );

    execute_stage #(.DMEM_WORDS(DMEM_WORDS)) u_exec (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .start_i      (start),
        .valid_i      (exec_valid),
        .fetch_i      (fetch_e),
        .host_raddr_i (host_raddr),
        .host_rdata_o (host_rdata),
        .redirect_o   (redirect),
        .target_o     (target),
        .flush_o      (flush),
        .status_o     (status),
        .retired_o    (retired)
    );

endmodule

`default_nettype wire

/* tb_rv_core_assertions.sv */
`default_nettype none

module tb_rv_core_assertions (
    input logic          clk_i,
    input logic          rst_n_i,
    input rv_pkg::word_t paddr_i,
    input logic          psel_i,
    input logic          penable_i,
    input logic          pready_i,
    input logic          pslverr_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int assert_fails = 0;  // read by the testbench at the end

    pready_in_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (psel_i && penable_i) |-> pready_i)
    else begin
        assert_fails++;
        $error("pready low during an APB access cycle");
    end

    slverr_with_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pslverr_i |-> (pready_i && penable_i))
    else begin
        assert_fails++;
        $error("pslverr high outside a completing access cycle");
    end

    // address held from setup into access
    addr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (psel_i && !penable_i) |=> $stable(paddr_i))
    else begin
        assert_fails++;
        $error("paddr changed between setup and access");
    end

endmodule

bind apb_host_port tb_rv_core_assertions u_apb_chk (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .paddr_i   (paddr_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pready_i  (pready_o),
    .pslverr_i (pslverr_o)
);

`default_nettype wire

/* tb_rv_core.sv */
`default_nettype none

module tb_rv_core;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_pkg::*;

    localparam int CLK_HALF = 4;

    logic  clk;
    logic  rst_n;
    word_t paddr;
    logic  psel;
    logic  penable;
    logic  pwrite;
    word_t pwdata;
    word_t prdata;
    logic  pready;
    logic  pslverr;

    // tests as read from the golden file, programs and registers kept flat
    string t_name[$];
    int    t_base[$];
    int    t_words[$];
    int    t_retired[$];
    int    t_reg_base[$];
    word_t prog[$];
    int    reg_idx[$];
    word_t reg_val[$];

    logic [31:0] lfsr_state;
    string       cur_test;
    int          test_errors;
    int          errors;
    int          pass_count;
    int          fail_count;
    int          cycles;
    int          cycle_limit;

    rv_core_top #(
        .IMEM_WORDS (64),
        .DMEM_WORDS (32)
    ) UUT (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .paddr_i   (paddr),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    always #CLK_HALF clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: core did not finish within %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic idle_gap();
        int n;
        n = 0;
        for (int b = 0; b < 2; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            n = (n << 1) | int'(lfsr_state[0]);
        end
        repeat (n) @(negedge clk);
    endtask

    task automatic apb_xfer(input word_t addr, input logic write, input word_t wdata,
                            output word_t rdata, output logic err);
        idle_gap();
        @(negedge clk);
        paddr   = addr;              // setup cycle
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;              // access cycle
        #1;
        rdata = prdata;
        err   = pslverr;
        compare_flag("pready in access cycle", 1'b1, pready);  // zero wait states
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input word_t addr, input word_t data, output logic err);
        word_t unused;
        apb_xfer(addr, 1'b1, data, unused, err);
    endtask

    task automatic apb_read(input word_t addr, output word_t data, output logic err);
        apb_xfer(addr, 1'b0, '0, data, err);
    endtask

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    task automatic compare_word(input string what, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("Error %s: %s expected %h actual %h", cur_test, what, exp, act);
            note_error();
        end
    endtask

    task automatic compare_status(input string what, input status_t exp, input status_t act);
        if (exp !== act) begin
            $display("Error %s: %s expected running=%b halted=%b actual running=%b halted=%b",
                     cur_test, what, exp.running, exp.halted, act.running, act.halted);
            note_error();
        end
    endtask

    task automatic compare_flag(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Error %s: %s expected %b actual %b", cur_test, what, exp, act);
            note_error();
        end
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            $display("test %s passed", cur_test);
            pass_count++;
        end else begin
            $display("test %s failed with %0d mismatches", cur_test, test_errors);
            fail_count++;
        end
    endtask

    task automatic read_golden(output bit ok);
        int    fd;
        int    code;
        int    idx;
        int    count;
        string tok;
        string name;
        string rest;
        word_t val;
        ok = 1'b0;
        fd = $fopen("core_golden.txt", "r");
        if (fd == 0) begin
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                code = $fgets(rest, fd);      // rest of a comment line
            end else if (tok == "test") begin
                code = $fscanf(fd, "%s %d", name, count);
                t_name.push_back(name);
                t_base.push_back(prog.size());
                t_words.push_back(count);
                t_reg_base.push_back(reg_idx.size());
                for (int i = 0; i < count; i++) begin
                    code = $fscanf(fd, "%h", val);
                    prog.push_back(val);
                end
            end else if (tok == "retired") begin
                code = $fscanf(fd, "%d", count);
                t_retired.push_back(count);
            end else if (tok == "reg") begin
                code = $fscanf(fd, "%d %h", idx, val);
                reg_idx.push_back(idx);
                reg_val.push_back(val);
            end
        end
        $fclose(fd);
        ok = (t_name.size() > 0) && (t_retired.size() == t_name.size());
    endtask

    task automatic load_program(input int t);
        logic err;
        for (int i = 0; i < t_words[t]; i++) begin
            apb_write(word_t'(4 * i), prog[t_base[t] + i], err);
            compare_flag($sformatf("imem write %0d pslverr", i), 1'b0, err);
        end
    endtask

    task automatic run_program(input int t);
        word_t   data;
        logic    err;
        status_t st;
        status_t exp_st;
        int      first;
        int      last;
        first = t_reg_base[t];
        last  = (t + 1 < t_name.size()) ? t_reg_base[t + 1] : reg_idx.size();
        apb_write(32'h180, 32'h1, err);
        compare_flag("start pslverr", 1'b0, err);
        apb_write(32'h0, 32'h00100073, err);       // core is running, so refused
        compare_flag("imem write while running pslverr", 1'b1, err);
        st.running = 1'b1;                         // nothing read yet
        st.halted  = 1'b0;
        while (st.running && !st.halted) begin
            apb_read(32'h184, data, err);
            compare_flag("status read pslverr", 1'b0, err);
            st = status_t'(data[1:0]);
        end
        exp_st.running = 1'b0;
        exp_st.halted  = 1'b1;
        compare_status("status", exp_st, st);
        apb_read(32'h188, data, err);
        compare_flag("retired count read pslverr", 1'b0, err);
        compare_word("retired count", word_t'(t_retired[t]), data);
        for (int r = first; r < last; r++) begin
            apb_read(word_t'(32'h100 + 4 * reg_idx[r]), data, err);
            compare_flag($sformatf("x%0d read pslverr", reg_idx[r]), 1'b0, err);
            compare_word($sformatf("x%0d", reg_idx[r]), reg_val[r], data);
        end
    endtask

    task automatic check_apb_errors(input int last_t);
        word_t data;
        logic  err;
        apb_write(32'h104, 32'h5a5a5a5a, err);
        compare_flag("write to register window pslverr", 1'b1, err);
        apb_read(32'h200, data, err);
        compare_flag("read of unmapped address pslverr", 1'b1, err);
        apb_read(32'h000, data, err);
        compare_flag("read of instruction memory pslverr", 1'b1, err);
        apb_read(32'h180, data, err);
        compare_flag("read of control pslverr", 1'b1, err);
        apb_read(32'h188, data, err);
        compare_flag("read of retired count pslverr", 1'b0, err);
        compare_word("retired count", word_t'(t_retired[last_t]), data);
    endtask

    initial begin
        bit ok;
        int assert_fails;
        clk         = 1'b0;
        rst_n       = 1'b0;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        lfsr_state  = 32'd84039;
        errors      = 0;
        pass_count  = 0;
        fail_count  = 0;
        cycles      = 0;
        cycle_limit = 0;
        read_golden(ok);
        if (!ok) begin
            $display("golden file core_golden.txt is missing or holds no complete test");
            $display("Checks failed");
            $finish;
        end else begin
            foreach (t_name[t]) begin
                cycle_limit += 40 * t_words[t] + 200;
            end
            repeat (3) @(negedge clk);
            rst_n = 1'b1;
            foreach (t_name[t]) begin
                begin_test(t_name[t]);
                load_program(t);
                run_program(t);
                end_test();
                begin_test({t_name[t], "_restart"});  // same program, no reload
                run_program(t);
                end_test();
            end
            begin_test("apb_errors");
            check_apb_errors(t_name.size() - 1);
            end_test();
            assert_fails = UUT.u_apb.u_apb_chk.assert_fails;
            $display("%0d tests passed, %0d tests failed, %0d assertion failures",
                     pass_count, fail_count, assert_fails);
            if (errors == 0 && assert_fails == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* core_golden.txt */
# test <name> <word count>, followed by that many program words in hex
# retired <decimal count>, then reg <index> <hex value> for each register checked
test arith 11
123450b7 67808093 00001117 ffb00193 00700213 403202b3
4041d333 0041d3b3 0050c433 0041a4b3 00100073
retired 11
reg 1 12345678 reg 2 00001008 reg 3 fffffffb reg 5 0000000c
reg 6 ffffffff reg 7 01ffffff reg 8 12345674 reg 9 00000001
test memory 9
05500093 fff00113 00800193 0011a023 0021a223 0001a203 0041a283 00520333 00100073
retired 9
reg 4 00000055 reg 5 ffffffff reg 6 00000054
test control 14
00000093 00500113 00108093 fe209ee3 00008463 01100193 00c0026f
07700193 07800193 03000293 00028367 09900193 00130393 00100073
retired 19
reg 1 00000005 reg 2 00000005 reg 3 00000011 reg 4 0000001c
reg 5 00000030 reg 6 0000002c reg 7 0000002d
test x0 5
12300013 abcde037 000000b3 00300113 00100073
retired 5
reg 0 00000000 reg 1 00000000 reg 2 00000003

/* tb.f */
rv_pkg.sv
pipe_reg.sv
fetch_stage.sv
main_decoder.sv
alu.sv
reg_file.sv
execute_stage.sv
apb_host_port.sv
rv_core_top.sv
tb_rv_core_assertions.sv
tb_rv_core.sv
